// File: hdl/rv_pkg.sv
package rv_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        LUI    = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_e;

    // Second ALU operand select
    localparam logic [1:0] alu_b_reg  = 2'd0;
    localparam logic [1:0] alu_b_four = 2'd1;
    localparam logic [1:0] alu_b_imm  = 2'd2;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One fetched word, viewed through the format its opcode selects
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    typedef enum logic [2:0] {
        FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK
    } state_e;

    typedef struct packed {
        logic       pc_write;
        logic       ir_write;
        logic       ab_load;
        logic       aluout_load;
        logic       mdr_load;
        logic       reg_write;
        logic       alu_a_sel;   // 0 PC, 1 A
        logic [1:0] alu_b_sel;
        alu_op_e    alu_op;
        logic       pc_sel;      // 0 ALU result, 1 ALUOut
        logic       mem_to_reg;
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        logic  write;
        word_t addr;
        word_t wdata;
    } bus_req_t;

    typedef struct packed {
        logic  psel;
        logic  penable;
        logic  pwrite;
        word_t paddr;
        word_t pwdata;
    } apb_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        word_t    data;
    } retire_t;

endpackage

// File: hdl/rv_alu.sv
`timescale 1ns/10ps
module rv_alu (
    input  rv_pkg::alu_op_e op,
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  logic [2:0]      funct3,
    output rv_pkg::word_t   result,
    output logic            cond_true
);
    import rv_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = {31'b0, $signed(a) < $signed(b)};
            SLTU:    result = {31'b0, a < b};
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = word_t'($signed(a) >>> shamt);  // sign fills from the left
            OR:      result = a | b;
            AND:     result = a & b;
            default: result = '0;
        endcase
    end

    // Branch compare on the register operands
    always_comb begin
        case (funct3)
            3'b000:  cond_true = (a == b);                    // beq
            3'b001:  cond_true = (a != b);                    // bne
            3'b100:  cond_true = ($signed(a) < $signed(b));   // blt
            3'b101:  cond_true = ($signed(a) >= $signed(b));  // bge
            3'b110:  cond_true = (a < b);                     // bltu
            3'b111:  cond_true = (a >= b);                    // bgeu
            default: cond_true = 1'b0;
        endcase
    end

endmodule

// File: hdl/rv_imm_gen.sv
`timescale 1ns/10ps
module rv_imm_gen (
    input  rv_pkg::instr_u ir,
    output rv_pkg::word_t  imm
);
    import rv_pkg::*;

    always_comb begin
        case (opcode_e'(ir.r.opcode))
            OP_IMM, LOAD: begin
                imm = {{20{ir.i.imm[11]}}, ir.i.imm};
            end
            STORE: begin
                imm = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
            end
            BRANCH: begin
                imm = {{20{ir.b.imm_12}}, ir.b.imm_11, ir.b.imm_10_5, ir.b.imm_4_1, 1'b0};
            end
            JAL: begin
                imm = {{12{ir.j.imm_20}}, ir.j.imm_19_12, ir.j.imm_11, ir.j.imm_10_1, 1'b0};
            end
            LUI: begin
                imm = {ir.u.imm, 12'b0};  // Low bits zero
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: hdl/rv_regfile.sv
`timescale 1ns/10ps
module rv_regfile #(
    parameter int num_regs = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  logic             we,
    input  rv_pkg::word_t    wdata,
    output rv_pkg::word_t    rdata1,
    output rv_pkg::word_t    rdata2
);
    import rv_pkg::*;

    word_t regs [num_regs];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin  // x0 stays zero
            regs[rd] <= wdata;
        end
    end

    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

// File: hdl/rv_apb_master.sv
`timescale 1ns/10ps
module rv_apb_master (
    input  logic             clk,
    input  logic             reset,
    input  rv_pkg::bus_req_t req,
    output rv_pkg::apb_t     apb,
    input  rv_pkg::word_t    prdata,
    input  logic             pready,
    output logic             done,
    output rv_pkg::word_t    rdata
);
    import rv_pkg::*;

    typedef enum logic [1:0] {IDLE, SETUP, ACCESS} phase_e;

    phase_e phase;
    word_t  addr_q;
    word_t  wdata_q;
    logic   write_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phase <= IDLE;
        end else begin
            case (phase)
                IDLE: begin
                    if (req.valid) begin
                        phase <= SETUP;
                    end
                end
                SETUP:   phase <= ACCESS;
                ACCESS: begin
                    if (pready) begin
                        phase <= IDLE;  // Back to idle before the next request
                    end
                end
                default: phase <= IDLE;
            endcase
        end
    end

    // Transfer fields captured once and held to completion
    always_ff @(posedge clk) begin
        if (phase == IDLE && req.valid) begin
            addr_q  <= req.addr;
            write_q <= req.write;
            wdata_q <= req.wdata;
        end
    end

    assign apb.psel    = (phase != IDLE);
    assign apb.penable = (phase == ACCESS);
    assign apb.pwrite  = write_q;
    assign apb.paddr   = addr_q;
    assign apb.pwdata  = wdata_q;

    assign done  = (phase == ACCESS) && pready;
    assign rdata = prdata;

    // Access phase only ever follows a setup cycle
    penable_after_setup: assert property (@(posedge clk) disable iff (reset)
        apb.penable |-> apb.psel && $past(apb.psel));

    hold_while_waiting: assert property (@(posedge clk) disable iff (reset)
        apb.penable && !pready |=> $stable({apb.paddr, apb.pwrite, apb.pwdata}));

endmodule

// File: hdl/rv_control.sv
`timescale 1ns/10ps
module rv_control (
    input  logic           clk,
    input  logic           reset,
    input  rv_pkg::instr_u ir,
    input  logic           cond_true,
    input  logic           bus_done,
    output rv_pkg::ctrl_t  ctrl,
    output logic           bus_start,
    output logic           bus_write
);
    import rv_pkg::*;

    state_e  state;
    state_e  next_state;
    opcode_e opcode;

    assign opcode = opcode_e'(ir.r.opcode);

    // alt is instruction bit 30 and selects SUB only in register form
    function automatic alu_op_e decode_alu(input logic [2:0] f3, input logic alt,
                                           input logic reg_form);
        case (f3)
            3'b000:  decode_alu = (alt && reg_form) ? SUB : ADD;
            3'b001:  decode_alu = SLL;
            3'b010:  decode_alu = SLT;
            3'b011:  decode_alu = SLTU;
            3'b100:  decode_alu = XOR;
            3'b101:  decode_alu = alt ? SRA : SRL;
            3'b110:  decode_alu = OR;
            default: decode_alu = AND;
        endcase
    endfunction

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ADD;
        bus_start   = 1'b0;
        bus_write   = 1'b0;
        next_state  = state;
        case (state)
            FETCH: begin
                bus_start        = 1'b1;
                ctrl.ir_write    = 1'b1;        // IR follows the bus until done
                ctrl.aluout_load = 1'b1;        // PC + 4 kept in ALUOut
                ctrl.alu_b_sel   = alu_b_four;
                if (bus_done) begin
                    next_state = DECODE;
                end
            end
            DECODE: begin
                ctrl.ab_load = 1'b1;
                if (opcode != JAL) begin
                    // Step PC and precompute the branch target together
                    ctrl.pc_write    = 1'b1;
                    ctrl.pc_sel      = 1'b1;
                    ctrl.aluout_load = 1'b1;
                    ctrl.alu_b_sel   = alu_b_imm;
                end
                next_state = EXECUTE;
            end
            EXECUTE: begin
                ctrl.alu_a_sel = 1'b1;
                case (opcode)
                    OP: begin
                        ctrl.alu_op      = decode_alu(ir.r.funct3, ir.r.funct7[5], 1'b1);
                        ctrl.aluout_load = 1'b1;
                        next_state       = WRITEBACK;
                    end
                    OP_IMM: begin
                        ctrl.alu_b_sel   = alu_b_imm;
                        ctrl.alu_op      = decode_alu(ir.r.funct3, ir.r.funct7[5], 1'b0);
                        ctrl.aluout_load = 1'b1;
                        next_state       = WRITEBACK;
                    end
                    LUI: begin
                        ctrl.alu_b_sel   = alu_b_imm;   // A reads x0 here
                        ctrl.aluout_load = 1'b1;
                        next_state       = WRITEBACK;
                    end
                    LOAD, STORE: begin
                        ctrl.alu_b_sel   = alu_b_imm;
                        ctrl.aluout_load = 1'b1;
                        next_state       = MEMORY;
                    end
                    BRANCH: begin
                        ctrl.pc_write = cond_true;
                        ctrl.pc_sel   = 1'b1;           // Target from decode
                        next_state    = FETCH;
                    end
                    JAL: begin
                        ctrl.alu_a_sel = 1'b0;
                        ctrl.alu_b_sel = alu_b_imm;
                        ctrl.pc_write  = 1'b1;
                        ctrl.reg_write = 1'b1;          // Link is still in ALUOut
                        next_state     = FETCH;
                    end
                    default: next_state = FETCH;
                endcase
            end
            MEMORY: begin
                bus_start     = 1'b1;
                bus_write     = (opcode == STORE);
                ctrl.mdr_load = 1'b1;
                if (bus_done) begin
                    next_state = (opcode == STORE) ? FETCH : WRITEBACK;
                end
            end
            WRITEBACK: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = (opcode == LOAD);
                next_state      = FETCH;
            end
            default: next_state = FETCH;
        endcase
    end

    state_legal: assert property (@(posedge clk) disable iff (reset)
        state inside {FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK});

endmodule

// File: hdl/rv_core_top.sv
`timescale 1ns/10ps
module rv_core_top #(
    parameter rv_pkg::word_t reset_pc = '0,
    parameter int            num_regs = 32
) (
    input  logic            clk,
    input  logic            reset,
    output rv_pkg::apb_t    apb,
    input  rv_pkg::word_t   prdata,
    input  logic            pready,
    output rv_pkg::retire_t retire
);
    import rv_pkg::*;

    ctrl_t    ctrl;
    instr_u   ir;
    word_t    pc;
    word_t    a_reg;
    word_t    b_reg;
    word_t    alu_out;
    word_t    mdr;
    word_t    rdata1;
    word_t    rdata2;
    word_t    imm;
    word_t    alu_a;
    word_t    alu_b;
    word_t    alu_result;
    word_t    wb_data;
    word_t    bus_rdata;
    reg_idx_t rs1_idx;
    logic     cond_true;
    logic     bus_start;
    logic     bus_write;
    logic     bus_done;
    bus_req_t bus_req;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (ctrl.pc_write) begin
            pc <= ctrl.pc_sel ? alu_out : alu_result;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_write) begin
            ir <= bus_rdata;
        end
        if (ctrl.ab_load) begin
            a_reg <= rdata1;
            b_reg <= rdata2;
        end
        if (ctrl.aluout_load) begin
            alu_out <= alu_result;
        end
        if (ctrl.mdr_load) begin
            mdr <= bus_rdata;
        end
    end

    assign rs1_idx = (ir.u.opcode == LUI) ? '0 : ir.r.rs1;  // LUI adds to zero

    assign alu_a = ctrl.alu_a_sel ? a_reg : pc;

    always_comb begin
        case (ctrl.alu_b_sel)
            alu_b_reg:  alu_b = b_reg;
            alu_b_four: alu_b = 32'd4;
            alu_b_imm:  alu_b = imm;
            default:    alu_b = b_reg;
        endcase
    end

    assign bus_req.valid = bus_start;
    assign bus_req.write = bus_write;
    assign bus_req.addr  = ctrl.ir_write ? pc : alu_out;  // Fetch or data access
    assign bus_req.wdata = b_reg;

    assign wb_data      = ctrl.mem_to_reg ? mdr : alu_out;
    assign retire.valid = ctrl.reg_write && (ir.r.rd != '0);
    assign retire.rd    = ir.r.rd;
    assign retire.data  = wb_data;

    rv_control u_control (
        .clk       (clk),
        .reset     (reset),
        .ir        (ir),
        .cond_true (cond_true),
        .bus_done  (bus_done),
        .ctrl      (ctrl),
        .bus_start (bus_start),
        .bus_write (bus_write)
    );

    rv_alu u_alu (
        .op        (ctrl.alu_op),
        .a         (alu_a),
        .b         (alu_b),
        .funct3    (ir.r.funct3),
        .result    (alu_result),
        .cond_true (cond_true)
    );

    rv_imm_gen u_imm_gen (
        .ir  (ir),
        .imm (imm)
    );

    rv_regfile #(
        .num_regs (num_regs)
    ) u_regfile (
        .clk    (clk),
        .reset  (reset),
        .rs1    (rs1_idx),
        .rs2    (ir.r.rs2),
        .rd     (ir.r.rd),
        .we     (ctrl.reg_write),
        .wdata  (wb_data),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    rv_apb_master u_apb_master (
        .clk    (clk),
        .reset  (reset),
        .req    (bus_req),
        .apb    (apb),
        .prdata (prdata),
        .pready (pready),
        .done   (bus_done),
        .rdata  (bus_rdata)
    );

endmodule

// File: sim/apb_mem_model.sv
`timescale 1ns/10ps
module apb_mem_model #(
    parameter int mem_words = 256
) (
    input  logic          clk,
    input  rv_pkg::apb_t  apb,
    output rv_pkg::word_t prdata,
    output logic          pready
);
    import rv_pkg::*;

    word_t       mem [mem_words];
    logic [1:0]  wait_left;
    int unsigned wait_pick;

    initial begin
        prdata    <= '0;
        pready    <= 1'b0;
        wait_left <= '0;
    end

    always @(posedge clk) begin
        if (apb.psel && !apb.penable) begin
            wait_pick = $urandom % 4;   // 0 to 3 wait cycles
            wait_left <= wait_pick[1:0];
            pready    <= (wait_pick == 0);
            prdata    <= mem[apb.paddr[9:2]];
        end else if (apb.psel && apb.penable) begin
            if (pready) begin
                if (apb.pwrite) begin
                    mem[apb.paddr[9:2]] <= apb.pwdata;
                end
                pready <= 1'b0;
            end else begin
                wait_left <= wait_left - 2'd1;
                if (wait_left == 2'd1) begin
                    pready <= 1'b1;
                end
            end
        end
    end

endmodule

// File: sim/rv_tb.sv
`timescale 1ns/10ps
module rv_tb;
    import rv_pkg::*;

    localparam int max_records  = 80;
    localparam int mem_words    = 256;
    localparam int retire_limit = 200;   // Cycles allowed between retirements

    logic    clk = 1'b0;
    logic    reset;
    apb_t    apb;
    word_t   prdata;
    logic    pready;
    retire_t retire;

    word_t    stim [3*max_records];
    reg_idx_t exp_rd [$];
    word_t    exp_data [$];

    always #2 clk = ~clk;

    rv_core_top #(
        .reset_pc (32'h0000_0000),
        .num_regs (32)
    ) u_dut (
        .clk    (clk),
        .reset  (reset),
        .apb    (apb),
        .prdata (prdata),
        .pready (pready),
        .retire (retire)
    );

    apb_mem_model #(
        .mem_words (mem_words)
    ) u_mem (
        .clk    (clk),
        .apb    (apb),
        .prdata (prdata),
        .pready (pready)
    );

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "Value mismatch");
        end
    endtask

    // Kind 1 is a program word, 2 a data word, 3 an expected retirement
    task automatic load_stimulus();
        word_t kind;
        word_t field;
        word_t value;
        for (int i = 0; i < mem_words; i++) begin
            u_mem.mem[i] <= 32'hbad0_0000 | word_t'(i << 2);
        end
        $readmemh("sim/rv_stimulus.txt", stim);
        for (int n = 0; n < max_records; n++) begin
            kind  = stim[3*n];
            field = stim[3*n+1];
            value = stim[3*n+2];
            if (kind === 32'd1 || kind === 32'd2) begin
                u_mem.mem[field[9:2]] <= value;
            end else if (kind === 32'd3) begin
                exp_rd.push_back(field[4:0]);
                exp_data.push_back(value);
            end
        end
    endtask

    initial begin
        int  cycles;
        bit  seen;
        reset <= 1'b1;
        void'($urandom(32'h9595_d194));
        load_stimulus();
        if (exp_rd.size() == 0) begin
            $display("The stimulus file holds no expected retirements");
            $display("Errors found");
            $fatal(1, "Empty stimulus");
        end

        // Two reset cycles with outputs sampled mid-cycle
        repeat (2) begin
            @(negedge clk);
            check_value("reset psel", 32'd0, {31'b0, apb.psel});
            check_value("reset retire valid", 32'd0, {31'b0, retire.valid});
        end
        @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("post reset psel", 32'd0, {31'b0, apb.psel});
        check_value("post reset retire valid", 32'd0, {31'b0, retire.valid});

        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 20) begin
            @(negedge clk);
            cycles++;
            seen = apb.psel;
        end
        if (!seen) begin
            $display("The core never started its first bus transfer after reset");
            $display("Errors found");
            $fatal(1, "No first fetch");
        end
        check_value("first fetch address", 32'h0000_0000, apb.paddr);

        for (int n = 0; n < exp_rd.size(); n++) begin
            cycles = 0;
            seen   = 1'b0;
            while (!seen && cycles < retire_limit) begin
                @(negedge clk);
                cycles++;
                seen = retire.valid;
            end
            if (!seen) begin
                $display("The core stopped retiring before expected entry %0d", n);
                $display("Errors found");
                $fatal(1, "Retirement timeout");
            end
            check_value($sformatf("retire %0d rd", n), word_t'(exp_rd[n]), word_t'(retire.rd));
            check_value($sformatf("retire %0d data", n), exp_data[n], retire.data);
        end

        $display("No errors");
        $finish;
    end

endmodule

// File: sim/rv_stimulus.txt
// Three words per line: kind, address or rd, value
// Kind 1 program word, 2 data word, 3 expected retirement (rd, value)
2 00000100 80000010
2 00000104 00000013
1 00000000 10002083
1 00000004 10402103
1 00000008 002081B3
1 0000000C 40208233
1 00000010 002112B3
1 00000014 0020A333
1 00000018 0020B3B3
1 0000001C 0020C433
1 00000020 0020D4B3
1 00000024 4020D533
1 00000028 0020E5B3
1 0000002C 0020F633
1 00000030 FFB00693
1 00000034 0016A713
1 00000038 0016B793
1 0000003C FFF0C813
1 00000040 10016893
1 00000044 07F0F913
1 00000048 00411993
1 0000004C 01C6DA13
1 00000050 4016DA93
1 00000054 12345B37
1 00000058 11602423
1 0000005C 10802B83
1 00000060 00510013
1 00000064 00200C33
1 00000068 00208463
1 0000006C 00100C93
1 00000070 00209463
1 00000074 06300D13
1 00000078 0020C463
1 0000007C 06300D13
1 00000080 00117463
1 00000084 00200D93
1 00000088 00800E6F
1 0000008C 06300D13
1 00000090 019E0EB3
1 00000094 0000006F
3 01 80000010
3 02 00000013
3 03 80000023
3 04 7FFFFFFD
3 05 00980000
3 06 00000001
3 07 00000000
3 08 80000003
3 09 00001000
3 0A FFFFF000
3 0B 80000013
3 0C 00000010
3 0D FFFFFFFB
3 0E 00000001
3 0F 00000000
3 10 7FFFFFEF
3 11 00000113
3 12 00000010
3 13 00000130
3 14 0000000F
3 15 FFFFFFFD
3 16 12345000
3 17 12345000
3 18 00000013
3 19 00000001
3 1B 00000002
3 1C 0000008C
3 1D 0000008D

// File: flist.f
hdl/rv_pkg.sv
hdl/rv_alu.sv
hdl/rv_imm_gen.sv
hdl/rv_regfile.sv
hdl/rv_apb_master.sv
hdl/rv_control.sv
hdl/rv_core_top.sv
sim/apb_mem_model.sv
sim/rv_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rv_tb -f flist.f -o rv_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/rv_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    exit 0
fi
exit 1
